// File: logic/cpuIsaPkg.sv
`default_nettype none

package cpuIsaPkg;

    localparam int regCount = 64;
    localparam int regIdxWidth = 6;
    localparam logic [regIdxWidth-1:0] linkReg = 6'd63;

    typedef enum logic [5:0] {
        opReg   = 6'd0,
        opAddi  = 6'd1,
        opLoad  = 6'd2,
        opStore = 6'd3,
        opJal   = 6'd4,
        opJr    = 6'd5,
        opBeqz  = 6'd6,
        opBnez  = 6'd7
    } opcodeE;

    typedef enum logic [5:0] {
        fnAdd = 6'd0,
        fnSub = 6'd1,
        fnAnd = 6'd2,
        fnOr  = 6'd3,
        fnXor = 6'd4,
        fnSlt = 6'd5,
        fnMul = 6'd6
    } functE;

    // Register format, bits 7:6 unused
    typedef struct packed {
        opcodeE                 opcode;
        logic [regIdxWidth-1:0] src1;
        logic [regIdxWidth-1:0] src2;
        logic [regIdxWidth-1:0] dest;
        logic [1:0]             spare;
        functE                  funct;
    } regFormT;

    typedef struct packed {
        opcodeE                 opcode;
        logic [regIdxWidth-1:0] src1;
        logic [regIdxWidth-1:0] dest;
        logic [13:0]            imm14;
    } immFormT;

    typedef union packed {
        regFormT regForm;
        immFormT immForm;
    } instrWord;

endpackage

`default_nettype wire

// File: logic/cpuCtrlPkg.sv
`default_nettype none

package cpuCtrlPkg;

    // Word address width of the program counter
    localparam int pcWidthDefault = 26;

    localparam int statusWidth = 3;

    // Encodings double as the status output
    typedef enum logic [statusWidth-1:0] {
        stFetch   = 3'd0,
        stDecode  = 3'd1,
        stExecute = 3'd2,
        stMemory  = 3'd3,
        stWrite   = 3'd4
    } ctrlStateE;

endpackage

`default_nettype wire

// File: logic/decodeIf.sv
`default_nettype none

interface decodeIf import cpuIsaPkg::*; ();

    logic [regIdxWidth-1:0] src1;
    logic [regIdxWidth-1:0] src2;
    logic [regIdxWidth-1:0] dest;
    logic [31:0]            imm;
    functE                  funct;
    logic                   useImm;
    logic                   isLoad;
    logic                   isStore;
    logic                   isJal;
    logic                   isJr;
    logic                   isBranch;
    logic                   branchOnZero;

    modport source (
        output src1, src2, dest, imm, funct, useImm,
        output isLoad, isStore, isJal, isJr, isBranch, branchOnZero
    );

    // Sequencing only needs the instruction class
    modport control (
        input isLoad, isStore, isJal, isJr, isBranch
    );

    modport datapath (
        input src1, src2, dest, imm, funct, useImm,
        input isLoad, isJal, isJr, isBranch, branchOnZero
    );

endinterface

`default_nettype wire

// File: logic/instructionDecoder.sv
`default_nettype none

module instructionDecoder import cpuIsaPkg::*; (
    input  logic        clock,
    input  logic        rstN,
    input  logic [31:0] instr,
    input  logic        decodeStrobe,
    decodeIf.source     dec
);

    instrWord    word;
    logic [25:0] jumpTarget;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            word <= '0;
        end else if (decodeStrobe) begin
            word <= instrWord'(instr);
        end
    end

    assign jumpTarget = word[25:0];

    always_comb begin
        // Immediate view is the default, register ops override
        dec.src1         = word.immForm.src1;
        dec.src2         = word.regForm.src2;
        dec.dest         = '0;
        dec.imm          = {{18{word.immForm.imm14[13]}}, word.immForm.imm14};
        dec.funct        = fnAdd;
        dec.useImm       = 1'b1;
        dec.isLoad       = 1'b0;
        dec.isStore      = 1'b0;
        dec.isJal        = 1'b0;
        dec.isJr         = 1'b0;
        dec.isBranch     = 1'b0;
        dec.branchOnZero = 1'b0;
        case (word.regForm.opcode)
            opReg: begin
                dec.dest   = word.regForm.dest;
                dec.funct  = word.regForm.funct;
                dec.useImm = 1'b0;
            end
            opAddi: dec.dest = word.immForm.dest;
            opLoad: begin
                dec.dest   = word.immForm.dest;
                dec.isLoad = 1'b1;
            end
            // Store data register sits in the dest field
            opStore: begin
                dec.src2    = word.immForm.dest;
                dec.isStore = 1'b1;
            end
            opJal: begin
                dec.dest  = linkReg;
                dec.imm   = {{6{jumpTarget[25]}}, jumpTarget};
                dec.isJal = 1'b1;
            end
            opJr: dec.isJr = 1'b1;
            opBeqz: begin
                dec.isBranch     = 1'b1;
                dec.branchOnZero = 1'b1;
            end
            opBnez: dec.isBranch = 1'b1;
            // Unknown opcodes write r0, which is a no-op
            default: dec.dest = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/controlUnit.sv
`default_nettype none

module controlUnit import cpuCtrlPkg::*; (
    input  logic                   clock,
    input  logic                   rstN,
    decodeIf.control               dec,
    input  logic                   instrDone,
    input  logic                   loadDone,
    input  logic                   storeDone,
    input  logic                   aluDone,
    input  logic                   condMet,
    output logic                   instrRead,
    output logic                   dataRead,
    output logic                   dataWrite,
    output logic                   decodeStrobe,
    output logic                   aluStart,
    output logic                   regWrite,
    output logic                   pcStep,
    output logic                   pcLoad,
    output logic [statusWidth-1:0] status
);

    ctrlStateE state;
    logic      takeJump;
    logic      writesReg;
    logic      memFinished;

    assign takeJump    = dec.isJal || dec.isJr || (dec.isBranch && condMet);
    assign writesReg   = !(dec.isStore || dec.isJr || dec.isBranch);
    assign memFinished = (dataRead && loadDone) || (dataWrite && storeDone);

    // Requests are registered so they stay low through reset
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state     <= stFetch;
            instrRead <= 1'b0;
            dataRead  <= 1'b0;
            dataWrite <= 1'b0;
            aluStart  <= 1'b0;
        end else begin
            aluStart <= 1'b0;
            case (state)
                stFetch: begin
                    if (instrRead && instrDone) begin
                        instrRead <= 1'b0;
                        state     <= stDecode;
                    end else begin
                        instrRead <= 1'b1;
                    end
                end
                stDecode: begin
                    aluStart <= 1'b1;
                    state    <= stExecute;
                end
                stExecute: begin
                    if (aluDone) begin
                        if (dec.isLoad) begin
                            dataRead <= 1'b1;
                            state    <= stMemory;
                        end else if (dec.isStore) begin
                            dataWrite <= 1'b1;
                            state     <= stMemory;
                        end else begin
                            state <= stWrite;
                        end
                    end
                end
                stMemory: begin
                    if (memFinished) begin
                        dataRead  <= 1'b0;
                        dataWrite <= 1'b0;
                        state     <= stWrite;
                    end
                end
                stWrite: begin
                    instrRead <= 1'b1;
                    state     <= stFetch;
                end
                default: state <= stFetch;
            endcase
        end
    end

    assign decodeStrobe = (state == stDecode);
    assign regWrite     = (state == stWrite) && writesReg;
    assign pcLoad       = (state == stWrite) && takeJump;
    assign pcStep       = (state == stWrite) && !takeJump;
    assign status       = state;

endmodule

`default_nettype wire

// File: logic/programCounter.sv
`default_nettype none

module programCounter import cpuCtrlPkg::*; #(
    parameter int pcWidth = pcWidthDefault
) (
    input  logic               clock,
    input  logic               rstN,
    input  logic               pcStep,
    input  logic               pcLoad,
    input  logic [pcWidth-1:0] nextPc,
    output logic [pcWidth-1:0] pc
);

    // Load wins over step, wraps at pcWidth
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (pcLoad) begin
            pc <= nextPc;
        end else if (pcStep) begin
            pc <= pc + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/registerFile.sv
`default_nettype none

module registerFile import cpuIsaPkg::*; (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic [regIdxWidth-1:0] readAddr1,
    input  logic [regIdxWidth-1:0] readAddr2,
    input  logic [regIdxWidth-1:0] writeAddr,
    input  logic [31:0]            writeData,
    input  logic                   writeEnable,
    output logic [31:0]            readData1,
    output logic [31:0]            readData2
);

    logic [31:0] regs [regCount];

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    // r0 is hardwired to zero
    assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
    assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

`default_nettype wire

// File: logic/aluUnit.sv
`default_nettype none

module aluUnit import cpuIsaPkg::*; (
    input  logic        clock,
    input  logic        rstN,
    input  logic [31:0] operandA,
    input  logic [31:0] operandB,
    input  functE       funct,
    input  logic        start,
    output logic        done,
    output logic [31:0] result
);

    logic        busy;
    logic [4:0]  stepCount;
    logic        launch;
    logic        lastStep;
    logic [31:0] product;
    logic [31:0] multiplicand;
    logic [31:0] multiplier;
    logic [31:0] partialSum;
    logic [31:0] simpleResult;

    assign launch     = start && !busy;
    assign lastStep   = busy && (stepCount == 5'd31);
    assign partialSum = multiplier[0] ? product + multiplicand : product;

    always_comb begin
        case (funct)
            fnAdd:   simpleResult = operandA + operandB;
            fnSub:   simpleResult = operandA - operandB;
            fnAnd:   simpleResult = operandA & operandB;
            fnOr:    simpleResult = operandA | operandB;
            fnXor:   simpleResult = operandA ^ operandB;
            fnSlt:   simpleResult = {31'b0, $signed(operandA) < $signed(operandB)};
            default: simpleResult = '0;
        endcase
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            busy      <= 1'b0;
            stepCount <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (launch && (funct == fnMul)) begin
                busy      <= 1'b1;
                stepCount <= '0;
            end else if (launch) begin
                done <= 1'b1;
            end else if (busy) begin
                stepCount <= stepCount + 5'd1;
                if (lastStep) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Shift-add, one multiplier bit per cycle
    always_ff @(posedge clock) begin
        if (launch) begin
            product      <= '0;
            multiplicand <= operandA;
            multiplier   <= operandB;
            if (funct != fnMul) begin
                result <= simpleResult;
            end
        end else if (busy) begin
            product      <= partialSum;
            multiplicand <= multiplicand << 1;
            multiplier   <= multiplier >> 1;
            if (lastStep) begin
                result <= partialSum;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/dataPath.sv
`default_nettype none

module dataPath import cpuCtrlPkg::*; #(
    parameter int pcWidth = pcWidthDefault
) (
    input  logic               clock,
    input  logic               rstN,
    decodeIf.datapath          dec,
    input  logic [pcWidth-1:0] pc,
    input  logic [31:0]        dataIn,
    input  logic               aluStart,
    input  logic               regWrite,
    output logic               aluDone,
    output logic               condMet,
    output logic [pcWidth-1:0] nextPc,
    output logic [31:0]        dataAddr,
    output logic [31:0]        dataOut
);

    logic [31:0] readData1;
    logic [31:0] readData2;
    logic [31:0] operandA;
    logic [31:0] operandB;
    logic [31:0] aluResult;
    logic [31:0] writeData;
    logic [31:0] loadData;
    logic [31:0] pcWide;

    // Holds the word seen with loadDone into the write cycle
    always_ff @(posedge clock) begin
        loadData <= dataIn;
    end

    assign pcWide   = {{(32-pcWidth){1'b0}}, pc};
    assign operandA = (dec.isJal || dec.isBranch) ? pcWide : readData1;
    assign operandB = dec.useImm ? dec.imm : readData2;

    always_comb begin
        if (dec.isJal) begin
            writeData = pcWide + 32'd1;
        end else if (dec.isLoad) begin
            writeData = loadData;
        end else begin
            writeData = aluResult;
        end
    end

    assign condMet  = ((readData1 == '0) == dec.branchOnZero);
    assign nextPc   = dec.isJr ? readData1[pcWidth-1:0] : aluResult[pcWidth-1:0];
    assign dataAddr = aluResult;
    assign dataOut  = readData2;

    registerFile regs (
        .clock      (clock),
        .rstN       (rstN),
        .readAddr1  (dec.src1),
        .readAddr2  (dec.src2),
        .writeAddr  (dec.dest),
        .writeData  (writeData),
        .writeEnable(regWrite),
        .readData1  (readData1),
        .readData2  (readData2)
    );

    aluUnit alu (
        .clock   (clock),
        .rstN    (rstN),
        .operandA(operandA),
        .operandB(operandB),
        .funct   (dec.funct),
        .start   (aluStart),
        .done    (aluDone),
        .result  (aluResult)
    );

endmodule

`default_nettype wire

// File: logic/cpuTop.sv
`default_nettype none

module cpuTop import cpuCtrlPkg::*; #(
    parameter int pcWidth = pcWidthDefault
) (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic [31:0]            instr,
    input  logic                   instrDone,
    input  logic [31:0]            dataIn,
    input  logic                   loadDone,
    input  logic                   storeDone,
    output logic [31:0]            instrAddr,
    output logic                   instrRead,
    output logic [31:0]            dataAddr,
    output logic [31:0]            dataOut,
    output logic                   dataRead,
    output logic                   dataWrite,
    output logic [statusWidth-1:0] status
);

    logic               decodeStrobe;
    logic               aluStart;
    logic               aluDone;
    logic               regWrite;
    logic               pcStep;
    logic               pcLoad;
    logic               condMet;
    logic [pcWidth-1:0] pc;
    logic [pcWidth-1:0] nextPc;

    decodeIf dec ();

    // Word address, zero-extended onto the bus
    assign instrAddr = {{(32-pcWidth){1'b0}}, pc};

    instructionDecoder decoder (
        .clock       (clock),
        .rstN        (rstN),
        .instr       (instr),
        .decodeStrobe(decodeStrobe),
        .dec         (dec.source)
    );

    controlUnit ctrl (
        .clock       (clock),
        .rstN        (rstN),
        .dec         (dec.control),
        .instrDone   (instrDone),
        .loadDone    (loadDone),
        .storeDone   (storeDone),
        .aluDone     (aluDone),
        .condMet     (condMet),
        .instrRead   (instrRead),
        .dataRead    (dataRead),
        .dataWrite   (dataWrite),
        .decodeStrobe(decodeStrobe),
        .aluStart    (aluStart),
        .regWrite    (regWrite),
        .pcStep      (pcStep),
        .pcLoad      (pcLoad),
        .status      (status)
    );

    programCounter #(.pcWidth(pcWidth)) pcUnit (
        .clock (clock),
        .rstN  (rstN),
        .pcStep(pcStep),
        .pcLoad(pcLoad),
        .nextPc(nextPc),
        .pc    (pc)
    );

    dataPath #(.pcWidth(pcWidth)) path (
        .clock   (clock),
        .rstN    (rstN),
        .dec     (dec.datapath),
        .pc      (pc),
        .dataIn  (dataIn),
        .aluStart(aluStart),
        .regWrite(regWrite),
        .aluDone (aluDone),
        .condMet (condMet),
        .nextPc  (nextPc),
        .dataAddr(dataAddr),
        .dataOut (dataOut)
    );

endmodule

`default_nettype wire

// File: verif/cpuTop_properties.sv
`default_nettype none

module cpuTopProperties import cpuCtrlPkg::*; (
    input logic                   clock,
    input logic                   rstN,
    input logic                   instrRead,
    input logic                   instrDone,
    input logic                   dataRead,
    input logic                   loadDone,
    input logic                   dataWrite,
    input logic                   storeDone,
    input logic [statusWidth-1:0] status
);

    timeunit 1ns;
    timeprecision 1ps;

    // Requests hold until their done strobe
    holdInstrRead: assert property (@(posedge clock) disable iff (!rstN)
        instrRead && !instrDone |=> instrRead)
        else $error("instrRead dropped before instrDone");

    holdDataRead: assert property (@(posedge clock) disable iff (!rstN)
        dataRead && !loadDone |=> dataRead)
        else $error("dataRead dropped before loadDone");

    holdDataWrite: assert property (@(posedge clock) disable iff (!rstN)
        dataWrite && !storeDone |=> dataWrite)
        else $error("dataWrite dropped before storeDone");

    noReadWithWrite: assert property (@(posedge clock) !(dataRead && dataWrite))
        else $error("dataRead and dataWrite are high together");

    validStatus: assert property (@(posedge clock) disable iff (!rstN)
        status <= 3'(stWrite))
        else $error("status holds an unknown state encoding");

    quietInReset: assert property (@(posedge clock) !rstN |-> !instrRead)
        else $error("instrRead is high while rstN is low");

endmodule

`default_nettype wire

// File: verif/cpuTb.sv
`default_nettype none

module cpuTb import cpuIsaPkg::*, cpuCtrlPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clockPeriod    = 4;
    localparam int numProgs       = 4;
    localparam int maxLen         = 32;
    localparam int maxStores      = 12;
    localparam int cyclesPerInstr = 60;

    logic        clock;
    logic        rstN      = 1'b0;
    logic [31:0] instr     = '0;
    logic        instrDone = 1'b0;
    logic [31:0] dataIn    = '0;
    logic        loadDone  = 1'b0;
    logic        storeDone = 1'b0;
    logic [31:0] instrAddr;
    logic        instrRead;
    logic [31:0] dataAddr;
    logic [31:0] dataOut;
    logic        dataRead;
    logic        dataWrite;
    logic [2:0]  status;

    // Program table with the ordered stores of each program
    logic [31:0] progCode  [numProgs][maxLen];
    int          progLen   [numProgs];
    int          progHalt  [numProgs];
    int          progSteps [numProgs];
    logic [31:0] storeAddr [numProgs][maxStores];
    logic [31:0] storeData [numProgs][maxStores];
    int          storeCount[numProgs];
    logic [31:0] preAddr   [numProgs][2];
    logic [31:0] preData   [numProgs][2];
    int          preCount  [numProgs];

    logic [31:0] imem [maxLen];
    logic [31:0] dmem [256];
    logic [31:0] lcgState   = 32'd13;
    int          curProg    = 0;
    int          storeIdx   = 0;
    int          dataWait   = -1;
    int          cycleCount = 0;
    int          cycleLimit = 0;
    int          errorCount = 0;

    cpuTop #(.pcWidth(26)) i_dut (
        .clock    (clock),
        .rstN     (rstN),
        .instr    (instr),
        .instrDone(instrDone),
        .dataIn   (dataIn),
        .loadDone (loadDone),
        .storeDone(storeDone),
        .instrAddr(instrAddr),
        .instrRead(instrRead),
        .dataAddr (dataAddr),
        .dataOut  (dataOut),
        .dataRead (dataRead),
        .dataWrite(dataWrite),
        .status   (status)
    );

    bind cpuTop cpuTopProperties props (
        .clock    (clock),
        .rstN     (rstN),
        .instrRead(instrRead),
        .instrDone(instrDone),
        .dataRead (dataRead),
        .loadDone (loadDone),
        .dataWrite(dataWrite),
        .storeDone(storeDone),
        .status   (status)
    );

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic logic [31:0] fillWord(input int addr);
        logic [31:0] a;
        a = addr;
        return (a * 32'h9E37_79B9) ^ {a[15:0], ~a[15:0]};
    endfunction

    // Instruction encoders
    function automatic logic [31:0] regOp(input functE f, input int d, input int s1,
                                          input int s2);
        return {opReg, 6'(s1), 6'(s2), 6'(d), 2'b00, f};
    endfunction

    function automatic logic [31:0] immOp(input opcodeE op, input int r, input int s1,
                                          input int imm);
        return {op, 6'(s1), 6'(r), 14'(imm)};
    endfunction

    function automatic logic [31:0] jalOp(input int offset);
        return {opJal, 26'(offset)};
    endfunction

    // Expected ALU result from the ISA rules
    function automatic logic [31:0] expectedAlu(input functE f, input logic [31:0] a,
                                                input logic [31:0] b);
        case (f)
            fnAdd:   return a + b;
            fnSub:   return a - b;
            fnAnd:   return a & b;
            fnOr:    return a | b;
            fnXor:   return a ^ b;
            fnSlt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return a * b;
        endcase
    endfunction

    task automatic stopOnFailure();
        errorCount++;
        $display("Checks failed");
        $fatal(1, "Stopped at the first failed check");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            stopOnFailure();
        end
    endtask

    task automatic emit(input int p, input logic [31:0] word);
        progCode[p][progLen[p]] = word;
        progLen[p]++;
    endtask

    // Halt is a jump-and-link to itself
    task automatic emitHalt(input int p);
        progHalt[p] = progLen[p];
        emit(p, jalOp(0));
    endtask

    task automatic expectStore(input int p, input logic [31:0] addr, input logic [31:0] value);
        storeAddr[p][storeCount[p]] = addr;
        storeData[p][storeCount[p]] = value;
        storeCount[p]++;
    endtask

    task automatic preload(input int p, input logic [31:0] addr, input logic [31:0] value);
        preAddr[p][preCount[p]] = addr;
        preData[p][preCount[p]] = value;
        preCount[p]++;
    endtask

    task automatic buildTable();
        int          a;
        int          b;
        logic [31:0] m1;
        logic [31:0] m2;
        a = -7;
        b = 5;
        // Arithmetic and then a write to r0
        emit(0, immOp(opAddi, 1, 0, a));
        emit(0, immOp(opAddi, 2, 0, b));
        for (int i = 0; i < 6; i++) begin
            emit(0, regOp(functE'(i), 3, 1, 2));
            emit(0, immOp(opStore, 3, 0, i + 1));
            expectStore(0, i + 1, expectedAlu(functE'(i), a, b));
        end
        emit(0, regOp(fnSlt, 3, 2, 1));
        emit(0, immOp(opStore, 3, 0, 7));
        expectStore(0, 7, expectedAlu(fnSlt, b, a));
        emit(0, immOp(opAddi, 0, 0, 9));
        emit(0, immOp(opStore, 0, 0, 8));
        expectStore(0, 8, 32'd0);
        emitHalt(0);
        // Multiply of random operands and then a load plus immediate
        m1 = nextRandom();
        m2 = nextRandom();
        preload(1, 16, m1);
        preload(1, 17, m2);
        emit(1, immOp(opLoad, 1, 0, 16));
        emit(1, immOp(opLoad, 2, 0, 17));
        emit(1, regOp(fnMul, 3, 1, 2));
        emit(1, immOp(opStore, 3, 0, 32));
        expectStore(1, 32, expectedAlu(fnMul, m1, m2));
        emit(1, immOp(opLoad, 4, 0, 40));
        emit(1, immOp(opAddi, 5, 4, -37));
        emit(1, immOp(opStore, 5, 0, 33));
        expectStore(1, 33, fillWord(40) - 32'd37);
        emitHalt(1);
        // Countdown loop followed by taken and not-taken branches
        emit(2, immOp(opAddi, 1, 0, 3));
        emit(2, immOp(opStore, 1, 1, 48));
        emit(2, immOp(opAddi, 1, 1, -1));
        emit(2, immOp(opBnez, 0, 1, -2));
        emit(2, immOp(opBeqz, 0, 1, 2));
        emit(2, immOp(opStore, 1, 0, 60));
        emit(2, immOp(opBnez, 0, 1, 2));
        emit(2, immOp(opAddi, 2, 0, 77));
        emit(2, immOp(opStore, 2, 0, 61));
        emit(2, immOp(opBeqz, 0, 2, 2));
        emit(2, immOp(opStore, 2, 0, 62));
        emitHalt(2);
        for (int k = 3; k > 0; k--) begin
            expectStore(2, 48 + k, k);
        end
        expectStore(2, 61, 32'd77);
        expectStore(2, 62, 32'd77);
        // Call at 1 to a subroutine at 5 that returns through r63
        emit(3, immOp(opAddi, 1, 0, 9));
        emit(3, jalOp(4));
        emit(3, immOp(opStore, 63, 0, 70));
        emit(3, immOp(opStore, 1, 0, 71));
        emitHalt(3);
        emit(3, immOp(opAddi, 1, 1, 1));
        emit(3, immOp(opJr, 0, 63, 0));
        expectStore(3, 70, 32'd2);
        expectStore(3, 71, 32'd10);
        for (int p = 0; p < numProgs; p++) begin
            progSteps[p] = progLen[p];
        end
        // Loop body runs three times
        progSteps[2] = progLen[2] + 6;
    endtask

    task automatic checkStore();
        assert (storeIdx < storeCount[curProg]) else begin
            $display("Program %0d issued more stores than expected, the extra one at %h",
                     curProg, dataAddr);
            stopOnFailure();
        end
        checkValue("dataAddr", storeAddr[curProg][storeIdx], dataAddr);
        checkValue("dataOut", storeData[curProg][storeIdx], dataOut);
        storeIdx++;
    endtask

    task automatic runProgram(input int p);
        @(posedge clock);
        rstN <= 1'b0;
        curProg  = p;
        storeIdx = 0;
        for (int i = 0; i < maxLen; i++) begin
            imem[i] = (i < progLen[p]) ? progCode[p][i] : '0;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fillWord(i);
        end
        for (int i = 0; i < preCount[p]; i++) begin
            dmem[preAddr[p][i][7:0]] = preData[p][i];
        end
        repeat (2) @(posedge clock);
        checkValue("instrAddr", 32'd0, instrAddr);
        checkValue("status", 32'(stFetch), 32'(status));
        checkValue("instrRead", 32'd0, 32'(instrRead));
        rstN <= 1'b1;
        do begin
            @(posedge clock);
        end while (!(instrRead && instrAddr == 32'(progHalt[p])));
        checkValue("store count", storeCount[p], storeIdx);
    endtask

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    // Instruction port answers one cycle after the request
    always @(posedge clock) begin
        if (!rstN) begin
            instrDone <= 1'b0;
        end else if (instrRead && !instrDone) begin
            instr     <= imem[instrAddr[4:0]];
            instrDone <= 1'b1;
        end else begin
            instrDone <= 1'b0;
        end
    end

    // Data port with a random delay of 0 to 5 cycles
    always @(posedge clock) begin
        loadDone  <= 1'b0;
        storeDone <= 1'b0;
        if (!rstN) begin
            dataWait <= -1;
        end else if ((dataRead || dataWrite) && !loadDone && !storeDone) begin
            if (dataWait < 0) begin
                dataWait <= int'((nextRandom() >> 16) % 32'd6);
            end else if (dataWait > 0) begin
                dataWait <= dataWait - 1;
            end else begin
                dataWait <= -1;
                if (dataRead) begin
                    dataIn   <= dmem[dataAddr[7:0]];
                    loadDone <= 1'b1;
                end else begin
                    checkStore();
                    dmem[dataAddr[7:0]] = dataOut;
                    storeDone <= 1'b1;
                end
            end
        end
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles, program %0d never reached its halt",
                     cycleCount, curProg);
            stopOnFailure();
        end
    end

    initial begin
        buildTable();
        // A few extra cycles per program cover its reset
        for (int p = 0; p < numProgs; p++) begin
            cycleLimit += progSteps[p] * cyclesPerInstr + 8;
        end
        for (int p = 0; p < numProgs; p++) begin
            runProgram(p);
        end
        if (errorCount == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "Run ended with failed checks");
        end
    end

endmodule

`default_nettype wire

// File: build.f
logic/cpuIsaPkg.sv
logic/cpuCtrlPkg.sv
logic/decodeIf.sv
logic/instructionDecoder.sv
logic/controlUnit.sv
logic/programCounter.sv
logic/registerFile.sv
logic/aluUnit.sv
logic/dataPath.sv
logic/cpuTop.sv
verif/cpuTop_properties.sv
verif/cpuTb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP      = cpuTb
FILELIST = build.f
BUILDDIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	@out="$$(./$(BUILDDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf $(BUILDDIR)
